// ==== design/mme_consts.svh ====
`ifndef MME_CONSTS_SVH
`define MME_CONSTS_SVH

// Array geometry
`define MME_ARRAY_W   8
`define MME_ARRAY_H   4
`define MME_PIPE_REGS 3

// Elements covered by one column tile
`define MME_COL_TILE  (`MME_ARRAY_H * (`MME_PIPE_REGS + 1))

// Size fields, leftovers and totals
`define MME_DIM_W     16
`define MME_LFT_W     8
`define MME_TOT_W     32

// Host register port
`define MME_REG_AW    2

`endif

// ==== design/mme_pkg.sv ====
`include "mme_consts.svh"

package mme_pkg;

  typedef enum logic [2:0] {
    OP_MATMUL = 3'd0,
    OP_GEMM   = 3'd1,
    OP_ADDMAX = 3'd2,
    OP_ADDMIN = 3'd3,
    OP_MULMAX = 3'd4,
    OP_MULMIN = 3'd5,
    OP_MAXMIN = 3'd6,
    OP_MINMAX = 3'd7
  } mme_op_e;

  typedef enum logic [1:0] {
    FMT_FP16    = 2'd0,
    FMT_FP8     = 2'd1,
    FMT_FP16ALT = 2'd2,
    FMT_FP8ALT  = 2'd3
  } mme_fmt_e;

  typedef enum logic {
    RND_RNE = 1'b0,
    RND_RTZ = 1'b1
  } mme_rnd_e;

  // Operation codes understood by the FPU stages
  typedef enum logic [2:0] {
    FPU_FMADD  = 3'd0,
    FPU_ADD    = 3'd2,
    FPU_MUL    = 3'd3,
    FPU_MINMAX = 3'd7
  } mme_fpu_op_e;

  typedef enum logic [2:0] {
    FPU_FP16    = 3'd2,
    FPU_FP8     = 3'd3,
    FPU_FP16ALT = 3'd4,
    FPU_FP8ALT  = 3'd5
  } mme_fpu_fmt_e;

  // Job as written by the host
  typedef struct packed {
    logic [`MME_DIM_W-1:0] m_size;
    logic [`MME_DIM_W-1:0] n_size;
    logic [`MME_DIM_W-1:0] k_size;
    mme_op_e               op;
    mme_fmt_e              in_fmt;
    mme_fmt_e              out_fmt;
  } mme_job_t;

  // Tiling, totals and datapath codes after decoding
  typedef struct packed {
    logic [`MME_DIM_W-1:0] x_rows_iter;
    logic [`MME_DIM_W-1:0] x_cols_iter;
    logic [`MME_DIM_W-1:0] w_rows_iter;
    logic [`MME_DIM_W-1:0] w_cols_iter;
    logic [`MME_LFT_W-1:0] x_rows_lftovr;
    logic [`MME_LFT_W-1:0] x_cols_lftovr;
    logic [`MME_LFT_W-1:0] w_rows_lftovr;
    logic [`MME_LFT_W-1:0] w_cols_lftovr;
    logic [`MME_DIM_W-1:0] tot_stores;
    logic [`MME_TOT_W-1:0] tot_x_read;
    logic [`MME_TOT_W-1:0] w_tot_len;
    mme_fpu_op_e           stage1_op;
    mme_fpu_op_e           stage2_op;
    mme_rnd_e              stage1_rnd;
    mme_rnd_e              stage2_rnd;
    mme_fpu_fmt_e          in_fpu_fmt;
    mme_fpu_fmt_e          out_fpu_fmt;
    logic                  gemm_sel;
  } mme_cfg_t;

endpackage

// ==== design/job_if.sv ====
`timescale 1ns/1ns

interface job_if
  import mme_pkg::*;
();

  mme_job_t job;
  logic     job_valid;
  logic     job_ready;
  // Pulses when the decoded config leaves the top level
  logic     job_done;

  modport regfile (
    output job,
    output job_valid,
    input  job_ready,
    input  job_done
  );

  modport decoder (
    input  job,
    input  job_valid,
    output job_ready,
    output job_done
  );

endinterface

// ==== design/job_regfile.sv ====
`timescale 1ns/1ns
`include "mme_consts.svh"

module job_regfile
  import mme_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   reg_we_i,
  input  logic [`MME_REG_AW-1:0] reg_addr_i,
  input  logic [`MME_TOT_W-1:0]  reg_wdata_i,
  output logic                   busy_o,
  job_if.regfile                 job_p
);

  localparam logic [`MME_REG_AW-1:0] ADDR_MK   = 'd0;
  localparam logic [`MME_REG_AW-1:0] ADDR_NOPS = 'd1;
  localparam logic [`MME_REG_AW-1:0] ADDR_TRIG = 'd2;

  logic [`MME_DIM_W-1:0] m_q;
  logic [`MME_DIM_W-1:0] n_q;
  logic [`MME_DIM_W-1:0] k_q;
  mme_op_e               op_q;
  mme_fmt_e              in_fmt_q;
  mme_fmt_e              out_fmt_q;
  logic                  busy_q;
  logic                  valid_q;

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      m_q       <= '0;
      n_q       <= '0;
      k_q       <= '0;
      op_q      <= OP_MATMUL;
      in_fmt_q  <= FMT_FP16;
      out_fmt_q <= FMT_FP16;
      busy_q    <= 1'b0;
      valid_q   <= 1'b0;
    end
    else
    begin
      // Parameters are frozen for the whole job
      if (reg_we_i && !busy_q && reg_addr_i == ADDR_MK)
      begin
        m_q <= reg_wdata_i[15:0];
        k_q <= reg_wdata_i[31:16];
      end
      if (reg_we_i && !busy_q && reg_addr_i == ADDR_NOPS)
      begin
        n_q       <= reg_wdata_i[15:0];
        op_q      <= mme_op_e'(reg_wdata_i[18:16]);
        in_fmt_q  <= mme_fmt_e'(reg_wdata_i[20:19]);
        out_fmt_q <= mme_fmt_e'(reg_wdata_i[22:21]);
      end
      if (reg_we_i && !busy_q && reg_addr_i == ADDR_TRIG)
      begin
        busy_q  <= 1'b1;
        valid_q <= 1'b1;
      end
      else
      begin
        if (valid_q && job_p.job_ready)
          valid_q <= 1'b0;
        if (job_p.job_done)
          busy_q <= 1'b0;
      end
    end
  end

  assign job_p.job = '{m_size: m_q, n_size: n_q, k_size: k_q, op: op_q,
                       in_fmt: in_fmt_q, out_fmt: out_fmt_q};
  assign job_p.job_valid = valid_q;
  assign busy_o          = busy_q;

  // The decoder only finishes a job that it has already taken
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    job_p.job_done |-> busy_q && !job_p.job_valid);

endmodule

// ==== design/seq_mult.sv ====
`timescale 1ns/1ns

module seq_mult #(
  parameter int unsigned AW = 16,
  parameter int unsigned BW = 16
) (
  input  logic          clk_i,
  input  logic          rst_ni,
  input  logic          start_i,
  input  logic [AW-1:0] a_i,
  input  logic [BW-1:0] b_i,
  output logic          ready_o,
  output logic          valid_o,
  output logic [31:0]   prod_o
);

  localparam int unsigned CW = (BW > 1) ? $clog2(BW) : 1;

  logic          run_q;
  logic          valid_q;
  logic [CW-1:0] cnt_q;
  logic [31:0]   a_sh_q;
  logic [BW-1:0] b_sh_q;
  logic [31:0]   acc_q;

  // One bit of B per cycle, A shifted along with it
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      run_q   <= 1'b0;
      valid_q <= 1'b0;
      cnt_q   <= '0;
      a_sh_q  <= '0;
      b_sh_q  <= '0;
      acc_q   <= '0;
    end
    else if (start_i && !run_q)
    begin
      run_q   <= 1'b1;
      valid_q <= 1'b0;
      cnt_q   <= '0;
      a_sh_q  <= 32'(a_i);
      b_sh_q  <= b_i;
      acc_q   <= '0;
    end
    else if (run_q)
    begin
      if (b_sh_q[0])
        acc_q <= acc_q + a_sh_q;
      a_sh_q <= a_sh_q << 1;
      b_sh_q <= b_sh_q >> 1;
      cnt_q  <= cnt_q + 1'b1;
      // Last bit consumed, product is final on the next cycle
      if (cnt_q == CW'(BW - 1))
      begin
        run_q   <= 1'b0;
        valid_q <= 1'b1;
      end
    end
  end

  assign ready_o = !run_q;
  assign valid_o = valid_q;
  assign prod_o  = acc_q;

  assert property (@(posedge clk_i) disable iff (!rst_ni) start_i |-> ready_o);

endmodule

// ==== design/job_decoder.sv ====
`timescale 1ns/1ns
`include "mme_consts.svh"

module job_decoder
  import mme_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_ni,
  job_if.decoder   job_p,
  output mme_cfg_t cfg_o,
  output logic     cfg_valid_o,
  input  logic     cfg_ready_i
);

  localparam int unsigned DW     = `MME_DIM_W;
  localparam int unsigned LW     = `MME_LFT_W;
  localparam int unsigned ROW_SH = $clog2(`MME_ARRAY_W);
  localparam int unsigned COL_SH = $clog2(`MME_COL_TILE);
  localparam int unsigned H_SH   = $clog2(`MME_ARRAY_H);

  logic                  take_job;
  logic                  cfg_take;
  logic                  busy_q;
  logic [DW-1:0]         x_rows_iter;
  logic [DW-1:0]         x_cols_iter;
  logic [DW-1:0]         w_cols_iter;
  logic [LW-1:0]         x_rows_lft;
  logic [LW-1:0]         x_cols_lft;
  logic [LW-1:0]         w_cols_lft;
  logic                  rc_ready;
  logic                  rc_valid;
  logic                  rc_valid_q;
  logic [`MME_TOT_W-1:0] rc_prod;
  logic                  tot_ready;
  logic                  tot_valid;
  logic                  tot_valid_q;
  logic [`MME_TOT_W-1:0] tot_prod;
  mme_cfg_t              cfg_d;
  mme_cfg_t              cfg_q;
  logic                  cfg_valid_q;

  function automatic mme_fpu_fmt_e to_fpu_fmt(input mme_fmt_e fmt);
    mme_fpu_fmt_e res;
    case (fmt)
      FMT_FP16:    res = FPU_FP16;
      FMT_FP8:     res = FPU_FP8;
      FMT_FP16ALT: res = FPU_FP16ALT;
      default:     res = FPU_FP8ALT;
    endcase
    return res;
  endfunction

  // Tiles are powers of two, so remainders are the low bits
  assign x_rows_lft  = LW'(job_p.job.m_size[ROW_SH-1:0]);
  assign x_cols_lft  = LW'(job_p.job.n_size[COL_SH-1:0]);
  assign w_cols_lft  = LW'(job_p.job.k_size[COL_SH-1:0]);
  assign x_rows_iter = (job_p.job.m_size >> ROW_SH) + DW'(x_rows_lft != '0);
  assign x_cols_iter = (job_p.job.n_size >> COL_SH) + DW'(x_cols_lft != '0);
  assign w_cols_iter = (job_p.job.k_size >> COL_SH) + DW'(w_cols_lft != '0);

  assign take_job = job_p.job_valid && job_p.job_ready;
  assign cfg_take = cfg_valid_q && cfg_ready_i;

  // Rows times columns, then scaled by N once the first product settles
  seq_mult #(
    .AW (DW),
    .BW (DW)
  ) u_rows_cols (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .start_i (take_job),
    .a_i     (x_rows_iter),
    .b_i     (w_cols_iter),
    .ready_o (rc_ready),
    .valid_o (rc_valid),
    .prod_o  (rc_prod)
  );

  seq_mult #(
    .AW (DW),
    .BW (`MME_TOT_W)
  ) u_tot (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .start_i (rc_valid && !rc_valid_q),
    .a_i     (job_p.job.n_size),
    .b_i     (rc_prod),
    .ready_o (tot_ready),
    .valid_o (tot_valid),
    .prod_o  (tot_prod)
  );

  always_comb
  begin
    cfg_d               = '0;
    cfg_d.x_rows_iter   = x_rows_iter;
    cfg_d.x_cols_iter   = x_cols_iter;
    cfg_d.w_rows_iter   = job_p.job.n_size;
    cfg_d.w_cols_iter   = w_cols_iter;
    cfg_d.x_rows_lftovr = x_rows_lft;
    cfg_d.x_cols_lftovr = x_cols_lft;
    cfg_d.w_rows_lftovr = LW'(job_p.job.n_size[H_SH-1:0]);
    cfg_d.w_cols_lftovr = w_cols_lft;
    cfg_d.tot_stores    = rc_prod[DW-1:0];
    // Chain result is already registered, a single multiplier fits here
    cfg_d.tot_x_read    = x_cols_iter * rc_prod[DW-1:0];
    cfg_d.w_tot_len     = tot_prod;
    case (job_p.job.op)
      OP_MATMUL, OP_GEMM:   cfg_d.stage1_op = FPU_FMADD;
      OP_ADDMAX, OP_ADDMIN: cfg_d.stage1_op = FPU_ADD;
      OP_MULMAX, OP_MULMIN: cfg_d.stage1_op = FPU_MUL;
      default:              cfg_d.stage1_op = FPU_MINMAX;
    endcase
    cfg_d.stage2_op     = FPU_MINMAX;
    cfg_d.stage1_rnd    = (job_p.job.op == OP_MAXMIN) ? RND_RTZ : RND_RNE;
    cfg_d.stage2_rnd    = (job_p.job.op inside {OP_ADDMAX, OP_MULMAX, OP_MINMAX}) ?
                          RND_RTZ : RND_RNE;
    cfg_d.in_fpu_fmt    = to_fpu_fmt(job_p.job.in_fmt);
    cfg_d.out_fpu_fmt   = to_fpu_fmt(job_p.job.out_fmt);
    cfg_d.gemm_sel      = (job_p.job.op != OP_MATMUL);
  end

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      busy_q      <= 1'b0;
      rc_valid_q  <= 1'b0;
      tot_valid_q <= 1'b0;
      cfg_valid_q <= 1'b0;
      cfg_q       <= '0;
    end
    else
    begin
      rc_valid_q  <= rc_valid;
      tot_valid_q <= tot_valid;
      if (take_job)
        busy_q <= 1'b1;
      else if (cfg_take)
        busy_q <= 1'b0;
      // Load once per job, then hold until the consumer takes it
      if (tot_valid && !tot_valid_q)
      begin
        cfg_q       <= cfg_d;
        cfg_valid_q <= 1'b1;
      end
      else if (cfg_take)
        cfg_valid_q <= 1'b0;
    end
  end

  assign job_p.job_ready = !busy_q && rc_ready && tot_ready;
  assign job_p.job_done  = cfg_take;
  assign cfg_o           = cfg_q;
  assign cfg_valid_o     = cfg_valid_q;

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    cfg_valid_o && !cfg_ready_i |=> cfg_valid_o && $stable(cfg_o));

endmodule

// ==== design/mme_cfg_top.sv ====
`timescale 1ns/1ns
`include "mme_consts.svh"

module mme_cfg_top
  import mme_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   reg_we_i,
  input  logic [`MME_REG_AW-1:0] reg_addr_i,
  input  logic [`MME_TOT_W-1:0]  reg_wdata_i,
  input  logic                   cfg_ready_i,
  output logic                   busy_o,
  output logic                   cfg_valid_o,
  output logic [`MME_DIM_W-1:0]  x_rows_iter_o,
  output logic [`MME_DIM_W-1:0]  x_cols_iter_o,
  output logic [`MME_DIM_W-1:0]  w_rows_iter_o,
  output logic [`MME_DIM_W-1:0]  w_cols_iter_o,
  output logic [`MME_LFT_W-1:0]  x_rows_lftovr_o,
  output logic [`MME_LFT_W-1:0]  x_cols_lftovr_o,
  output logic [`MME_LFT_W-1:0]  w_rows_lftovr_o,
  output logic [`MME_LFT_W-1:0]  w_cols_lftovr_o,
  output logic [`MME_DIM_W-1:0]  tot_stores_o,
  output logic [`MME_TOT_W-1:0]  tot_x_read_o,
  output logic [`MME_TOT_W-1:0]  w_tot_len_o,
  output mme_fpu_op_e            stage1_op_o,
  output mme_fpu_op_e            stage2_op_o,
  output mme_rnd_e               stage1_rnd_o,
  output mme_rnd_e               stage2_rnd_o,
  output mme_fpu_fmt_e           in_fpu_fmt_o,
  output mme_fpu_fmt_e           out_fpu_fmt_o,
  output logic                   gemm_sel_o
);

  mme_cfg_t cfg;

  job_if u_job_if ();

  job_regfile u_regfile (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .reg_we_i    (reg_we_i),
    .reg_addr_i  (reg_addr_i),
    .reg_wdata_i (reg_wdata_i),
    .busy_o      (busy_o),
    .job_p       (u_job_if.regfile)
  );

  job_decoder u_decoder (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .job_p       (u_job_if.decoder),
    .cfg_o       (cfg),
    .cfg_valid_o (cfg_valid_o),
    .cfg_ready_i (cfg_ready_i)
  );

  // Flatten the decoded config onto plain ports
  assign x_rows_iter_o   = cfg.x_rows_iter;
  assign x_cols_iter_o   = cfg.x_cols_iter;
  assign w_rows_iter_o   = cfg.w_rows_iter;
  assign w_cols_iter_o   = cfg.w_cols_iter;
  assign x_rows_lftovr_o = cfg.x_rows_lftovr;
  assign x_cols_lftovr_o = cfg.x_cols_lftovr;
  assign w_rows_lftovr_o = cfg.w_rows_lftovr;
  assign w_cols_lftovr_o = cfg.w_cols_lftovr;
  assign tot_stores_o    = cfg.tot_stores;
  assign tot_x_read_o    = cfg.tot_x_read;
  assign w_tot_len_o     = cfg.w_tot_len;
  assign stage1_op_o     = cfg.stage1_op;
  assign stage2_op_o     = cfg.stage2_op;
  assign stage1_rnd_o    = cfg.stage1_rnd;
  assign stage2_rnd_o    = cfg.stage2_rnd;
  assign in_fpu_fmt_o    = cfg.in_fpu_fmt;
  assign out_fpu_fmt_o   = cfg.out_fpu_fmt;
  assign gemm_sel_o      = cfg.gemm_sel;

endmodule

// ==== dv/mme_cfg_tb.sv ====
`timescale 1ns/1ns
`include "mme_consts.svh"

module mme_cfg_tb
  import mme_pkg::*;
();

  // 23 jobs of at most 100 cycles each, plus idle time after the busy writes
  localparam int NUM_JOBS   = 23;
  localparam int JOB_CYCLES = 100;
  localparam int MAX_CYCLES = NUM_JOBS * JOB_CYCLES + 200;

  logic                   clk_i;
  logic                   rst_ni;
  logic                   reg_we_i;
  logic [`MME_REG_AW-1:0] reg_addr_i;
  logic [`MME_TOT_W-1:0]  reg_wdata_i;
  logic                   cfg_ready_i;
  logic                   busy_o;
  logic                   cfg_valid_o;
  wire mme_cfg_t          got_cfg;

  mme_cfg_t              exp_cfg = '0;
  logic [`MME_DIM_W-1:0] sh_m = '0;
  logic [`MME_DIM_W-1:0] sh_n = '0;
  logic [`MME_DIM_W-1:0] sh_k = '0;
  mme_op_e               sh_op = OP_MATMUL;
  mme_fmt_e              sh_in = FMT_FP16;
  mme_fmt_e              sh_out = FMT_FP16;
  logic [15:0]           lfsr_q = 16'd53;
  int                    trig_cnt = 0;
  int                    take_cnt = 0;
  int                    err_cnt = 0;
  int                    errs_before = 0;
  int                    test_cnt = 0;
  int                    cycle_cnt = 0;

  mme_cfg_top DUT (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .reg_we_i        (reg_we_i),
    .reg_addr_i      (reg_addr_i),
    .reg_wdata_i     (reg_wdata_i),
    .cfg_ready_i     (cfg_ready_i),
    .busy_o          (busy_o),
    .cfg_valid_o     (cfg_valid_o),
    .x_rows_iter_o   (got_cfg.x_rows_iter),
    .x_cols_iter_o   (got_cfg.x_cols_iter),
    .w_rows_iter_o   (got_cfg.w_rows_iter),
    .w_cols_iter_o   (got_cfg.w_cols_iter),
    .x_rows_lftovr_o (got_cfg.x_rows_lftovr),
    .x_cols_lftovr_o (got_cfg.x_cols_lftovr),
    .w_rows_lftovr_o (got_cfg.w_rows_lftovr),
    .w_cols_lftovr_o (got_cfg.w_cols_lftovr),
    .tot_stores_o    (got_cfg.tot_stores),
    .tot_x_read_o    (got_cfg.tot_x_read),
    .w_tot_len_o     (got_cfg.w_tot_len),
    .stage1_op_o     (got_cfg.stage1_op),
    .stage2_op_o     (got_cfg.stage2_op),
    .stage1_rnd_o    (got_cfg.stage1_rnd),
    .stage2_rnd_o    (got_cfg.stage2_rnd),
    .in_fpu_fmt_o    (got_cfg.in_fpu_fmt),
    .out_fpu_fmt_o   (got_cfg.out_fpu_fmt),
    .gemm_sel_o      (got_cfg.gemm_sel)
  );

  initial
  begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  function automatic mme_fpu_fmt_e fpu_code(input mme_fmt_e f);
    case (f)
      FMT_FP16:    return FPU_FP16;
      FMT_FP8:     return FPU_FP8;
      FMT_FP16ALT: return FPU_FP16ALT;
      default:     return FPU_FP8ALT;
    endcase
  endfunction

  // Tiling, totals and datapath codes of one job
  function automatic mme_cfg_t expected_cfg(input logic [15:0] m, input logic [15:0] n,
                                            input logic [15:0] k, input mme_op_e op,
                                            input mme_fmt_e in_fmt, input mme_fmt_e out_fmt);
    mme_cfg_t    c;
    logic [31:0] tiles;
    c = '0;
    c.x_rows_iter   = 16'((32'(m) + 7) / 8);
    c.x_cols_iter   = 16'((32'(n) + 15) / 16);
    c.w_rows_iter   = n;
    c.w_cols_iter   = 16'((32'(k) + 15) / 16);
    c.x_rows_lftovr = 8'(m % 8);
    c.x_cols_lftovr = 8'(n % 16);
    c.w_rows_lftovr = 8'(n % 4);
    c.w_cols_lftovr = 8'(k % 16);
    tiles           = 32'(c.x_rows_iter) * 32'(c.w_cols_iter);
    c.tot_stores    = tiles[15:0];
    c.tot_x_read    = 32'(c.x_cols_iter) * 32'(c.tot_stores);
    c.w_tot_len     = 32'(n) * tiles;
    if (op == OP_MATMUL || op == OP_GEMM)
      c.stage1_op = FPU_FMADD;
    else if (op == OP_ADDMAX || op == OP_ADDMIN)
      c.stage1_op = FPU_ADD;
    else if (op == OP_MULMAX || op == OP_MULMIN)
      c.stage1_op = FPU_MUL;
    else
      c.stage1_op = FPU_MINMAX;
    c.stage2_op   = FPU_MINMAX;
    c.stage1_rnd  = (op == OP_MAXMIN) ? RND_RTZ : RND_RNE;
    c.stage2_rnd  = (op == OP_ADDMAX || op == OP_MULMAX || op == OP_MINMAX) ? RND_RTZ : RND_RNE;
    c.in_fpu_fmt  = fpu_code(in_fmt);
    c.out_fpu_fmt = fpu_code(out_fmt);
    c.gemm_sel    = (op != OP_MATMUL);
    return c;
  endfunction

  // Fibonacci LFSR, taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[0] ^ s[2] ^ s[3] ^ s[5], s[15:1]};
  endfunction

  task automatic rand_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr_q = lfsr_next(lfsr_q);
      v = {v[30:0], lfsr_q[0]};
    end
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] got);
    err_cnt++;
    $display("mismatch %s: expected %h, got %h", name, exp, got);
  endtask

  task automatic report_failure(input string msg);
    err_cnt++;
    $display("error: %s", msg);
  endtask

  // Job registers as the host last wrote them while idle
  always @(posedge clk_i)
  begin
    if (rst_ni && reg_we_i && !busy_o)
    begin
      if (reg_addr_i == 2'd0)
      begin
        sh_m <= reg_wdata_i[15:0];
        sh_k <= reg_wdata_i[31:16];
      end
      else if (reg_addr_i == 2'd1)
      begin
        sh_n   <= reg_wdata_i[15:0];
        sh_op  <= mme_op_e'(reg_wdata_i[18:16]);
        sh_in  <= mme_fmt_e'(reg_wdata_i[20:19]);
        sh_out <= mme_fmt_e'(reg_wdata_i[22:21]);
      end
      else if (reg_addr_i == 2'd2)
      begin
        exp_cfg  <= expected_cfg(sh_m, sh_n, sh_k, sh_op, sh_in, sh_out);
        trig_cnt <= trig_cnt + 1;
      end
    end
    if (cfg_valid_o && cfg_ready_i)
      take_cnt <= take_cnt + 1;
  end

  always @(posedge clk_i)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES)
    begin
      $display("timeout: run stopped after %0d cycles", cycle_cnt);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  property at_take(got, exp);
    @(posedge clk_i) disable iff (!rst_ni) cfg_valid_o && cfg_ready_i |-> got == exp;
  endproperty

  assert property (at_take(got_cfg.x_rows_iter, exp_cfg.x_rows_iter))
    else report_mismatch("x_rows_iter_o", exp_cfg.x_rows_iter, got_cfg.x_rows_iter);
  assert property (at_take(got_cfg.x_cols_iter, exp_cfg.x_cols_iter))
    else report_mismatch("x_cols_iter_o", exp_cfg.x_cols_iter, got_cfg.x_cols_iter);
  assert property (at_take(got_cfg.w_rows_iter, exp_cfg.w_rows_iter))
    else report_mismatch("w_rows_iter_o", exp_cfg.w_rows_iter, got_cfg.w_rows_iter);
  assert property (at_take(got_cfg.w_cols_iter, exp_cfg.w_cols_iter))
    else report_mismatch("w_cols_iter_o", exp_cfg.w_cols_iter, got_cfg.w_cols_iter);
  assert property (at_take(got_cfg.x_rows_lftovr, exp_cfg.x_rows_lftovr))
    else report_mismatch("x_rows_lftovr_o", exp_cfg.x_rows_lftovr, got_cfg.x_rows_lftovr);
  assert property (at_take(got_cfg.x_cols_lftovr, exp_cfg.x_cols_lftovr))
    else report_mismatch("x_cols_lftovr_o", exp_cfg.x_cols_lftovr, got_cfg.x_cols_lftovr);
  assert property (at_take(got_cfg.w_rows_lftovr, exp_cfg.w_rows_lftovr))
    else report_mismatch("w_rows_lftovr_o", exp_cfg.w_rows_lftovr, got_cfg.w_rows_lftovr);
  assert property (at_take(got_cfg.w_cols_lftovr, exp_cfg.w_cols_lftovr))
    else report_mismatch("w_cols_lftovr_o", exp_cfg.w_cols_lftovr, got_cfg.w_cols_lftovr);
  assert property (at_take(got_cfg.tot_stores, exp_cfg.tot_stores))
    else report_mismatch("tot_stores_o", exp_cfg.tot_stores, got_cfg.tot_stores);
  assert property (at_take(got_cfg.tot_x_read, exp_cfg.tot_x_read))
    else report_mismatch("tot_x_read_o", exp_cfg.tot_x_read, got_cfg.tot_x_read);
  assert property (at_take(got_cfg.w_tot_len, exp_cfg.w_tot_len))
    else report_mismatch("w_tot_len_o", exp_cfg.w_tot_len, got_cfg.w_tot_len);
  assert property (at_take(got_cfg.stage1_op, exp_cfg.stage1_op))
    else report_mismatch("stage1_op_o", exp_cfg.stage1_op, got_cfg.stage1_op);
  assert property (at_take(got_cfg.stage2_op, exp_cfg.stage2_op))
    else report_mismatch("stage2_op_o", exp_cfg.stage2_op, got_cfg.stage2_op);
  assert property (at_take(got_cfg.stage1_rnd, exp_cfg.stage1_rnd))
    else report_mismatch("stage1_rnd_o", exp_cfg.stage1_rnd, got_cfg.stage1_rnd);
  assert property (at_take(got_cfg.stage2_rnd, exp_cfg.stage2_rnd))
    else report_mismatch("stage2_rnd_o", exp_cfg.stage2_rnd, got_cfg.stage2_rnd);
  assert property (at_take(got_cfg.in_fpu_fmt, exp_cfg.in_fpu_fmt))
    else report_mismatch("in_fpu_fmt_o", exp_cfg.in_fpu_fmt, got_cfg.in_fpu_fmt);
  assert property (at_take(got_cfg.out_fpu_fmt, exp_cfg.out_fpu_fmt))
    else report_mismatch("out_fpu_fmt_o", exp_cfg.out_fpu_fmt, got_cfg.out_fpu_fmt);
  assert property (at_take(got_cfg.gemm_sel, exp_cfg.gemm_sel))
    else report_mismatch("gemm_sel_o", exp_cfg.gemm_sel, got_cfg.gemm_sel);

  // Nothing is busy or offered before the first trigger, nor while idle
  assert property (@(posedge clk_i) disable iff (!rst_ni) trig_cnt == 0 |-> !busy_o)
    else report_failure("busy_o went high before any trigger");
  assert property (@(posedge clk_i) disable iff (!rst_ni) !busy_o |-> !cfg_valid_o)
    else report_failure("cfg_valid_o high while the engine is idle");
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    reg_we_i && reg_addr_i == 2'd2 && !busy_o |-> ##[1:64] cfg_valid_o)
    else report_failure("cfg_valid_o did not rise within 64 cycles of the trigger");
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    cfg_valid_o && !cfg_ready_i |=> cfg_valid_o && $stable(got_cfg))
    else report_failure("config dropped or changed while held back");
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    cfg_valid_o && cfg_ready_i |-> take_cnt < trig_cnt)
    else report_failure("more configs delivered than triggers accepted");

  // Called right after a rising edge; the write is sampled on the next one
  task automatic write_reg(input logic [1:0] addr, input logic [31:0] data);
    reg_we_i    <= 1'b1;
    reg_addr_i  <= addr;
    reg_wdata_i <= data;
    @(posedge clk_i);
    reg_we_i <= 1'b0;
  endtask

  task automatic take_config(input int stall);
    while (!cfg_valid_o)
      @(posedge clk_i);
    repeat (stall) @(posedge clk_i);
    cfg_ready_i <= 1'b1;
    @(posedge clk_i);
    cfg_ready_i <= 1'b0;
  endtask

  task automatic run_job(input logic [15:0] m, input logic [15:0] n, input logic [15:0] k,
                         input logic [2:0] op, input logic [1:0] in_fmt,
                         input logic [1:0] out_fmt, input int stall);
    write_reg(2'd0, {k, m});
    write_reg(2'd1, {9'd0, out_fmt, in_fmt, op, n});
    write_reg(2'd2, 32'd0);
    take_config(stall);
  endtask

  task automatic finish_test(input string name);
    @(posedge clk_i);
    assert (take_cnt == trig_cnt)
      else report_failure("number of configs taken differs from triggers accepted");
    test_cnt++;
    $display("test %0d %s: %s", test_cnt, name, (err_cnt == errs_before) ? "ok" : "errors");
    errs_before = err_cnt;
  endtask

  initial
  begin
    logic [31:0] m;
    logic [31:0] n;
    logic [31:0] k;
    logic [31:0] op;
    logic [31:0] fi;
    logic [31:0] fo;
    logic [31:0] st;
    rst_ni      = 1'b0;
    reg_we_i    = 1'b0;
    reg_addr_i  = '0;
    reg_wdata_i = '0;
    cfg_ready_i = 1'b0;
    repeat (2) @(posedge clk_i);
    rst_ni <= 1'b1;
    repeat (6) @(posedge clk_i);
    finish_test("reset state");

    run_job(16'd16, 16'd32, 16'd48, 3'd1, 2'd0, 2'd1, 0);
    finish_test("exact tile multiples");

    for (int i = 0; i < 10; i++)
    begin
      rand_bits(12, m);
      rand_bits(12, n);
      rand_bits(12, k);
      rand_bits(3, op);
      rand_bits(2, fi);
      rand_bits(2, fo);
      // Odd sizes always leave a partial tile
      run_job(16'(m) | 16'd1, 16'(n) | 16'd1, 16'(k) | 16'd1, op[2:0], fi[1:0], fo[1:0], 0);
    end
    finish_test("random sizes with leftovers");

    for (int i = 0; i < 8; i++)
      run_job(16'd20, 16'd40, 16'd36, 3'(i), 2'(i % 4), 2'(3 - i % 4), 0);
    finish_test("operation and format table");

    for (int i = 0; i < 3; i++)
    begin
      rand_bits(5, st);
      rand_bits(10, n);
      run_job(16'd100, 16'(n) + 16'd1, 16'd70, 3'(i + 2), 2'd2, 2'd3, int'(st) + 1);
    end
    finish_test("back-pressure on the output");

    // Second parameter set and trigger land while the first job is running
    write_reg(2'd0, {16'd33, 16'd9});
    write_reg(2'd1, {9'd0, 2'd1, 2'd3, 3'd6, 16'd50});
    write_reg(2'd2, 32'd0);
    write_reg(2'd0, {16'd1000, 16'd2000});
    write_reg(2'd1, {9'd0, 2'd0, 2'd0, 3'd0, 16'd3000});
    write_reg(2'd2, 32'd0);
    take_config(0);
    repeat (80) @(posedge clk_i);
    assert (!busy_o && !cfg_valid_o)
      else report_failure("a trigger written while busy started a second job");
    finish_test("writes while busy");

    $display("%0d tests run, %0d configs taken, %0d errors", test_cnt, take_cnt, err_cnt);
    if (err_cnt == 0)
      $display("TESTBENCH PASSED");
    else
      $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

// ==== mme_cfg_top.f ====
+incdir+design
design/mme_pkg.sv
design/job_if.sv
design/job_regfile.sv
design/seq_mult.sv
design/job_decoder.sv
design/mme_cfg_top.sv
dv/mme_cfg_tb.sv
